//--- all.f
+incdir+include
src/fp16_pkg.sv
src/fp16_unpack.sv
src/mul_wallacetree.sv
src/fp16_exp_path.sv
src/fp16_round_pack.sv
src/fp16_mul_top.sv
tests/tb_clock_gen.sv
tests/fp16_mul_tb.sv

//--- Makefile
# Verilator build and run for the fp16 multiplier testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= fp16_mul_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: pass message not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/fp16_mul_tb.sv
//////////////////////////////////////////////////
// fp16 multiplier testbench, seeded random and
// directed operands, scoreboard against an integer
// model, per-test report and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fp16_defines.svh"

module fp16_mul_tb;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int N_RAND        = 200;
    localparam int N_SPECIAL     = 99;
    localparam int N_LARGE       = 60;
    localparam int N_SMALL       = 40;
    localparam int N_SUB         = 20;
    localparam int N_GAP         = 150;
    localparam int N_RST         = 20;
    // op and gap cycles plus the directed extras
    localparam int TOTAL_OPS     = N_RAND + N_SPECIAL + N_LARGE + 4 + N_SMALL + N_SUB + 2
                                   + N_GAP + 2 * N_RST + 2;
    localparam int WATCHDOG_CYC  = TOTAL_OPS * 3 + RESET_CYCLES + 200;

    logic        clk;
    logic        nRST;
    logic        in_valid;
    logic [15:0] a_in;
    logic [15:0] b_in;
    logic [15:0] product;
    logic        out_valid;
    logic        overflow_flag;
    logic        inexact_flag;
    logic        invalid_flag;

    // scoreboard with one entry per issued op
    logic [15:0] q_word  [$];
    logic [2:0]  q_flags [$];
    int          q_cyc   [$];

    logic [15:0] prev_word  = '0;
    logic [2:0]  prev_flags = '0;
    int          cyc         = 0;
    bit          mon_on      = 1'b0;
    int          err_count   = 0;
    int          check_count = 0;
    int          op_count    = 0;
    int          test_num    = 0;
    int          err_mark    = 0;
    int          op_mark     = 0;

    logic [15:0] specials [9] = '{16'h0000, 16'h8000, 16'h7C00, 16'hFC00, 16'h7E00,
                                  16'hFE55, 16'h7C01, 16'hFD00, 16'h0201};

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk(clk));

    fp16_mul_top u_dut (
        .clk           (clk),
        .nRST          (nRST),
        .in_valid      (in_valid),
        .a_in          (a_in),
        .b_in          (b_in),
        .product       (product),
        .out_valid     (out_valid),
        .overflow_flag (overflow_flag),
        .inexact_flag  (inexact_flag),
        .invalid_flag  (invalid_flag)
    );

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // reference model returning {overflow, inexact, invalid, word}
    function automatic logic [18:0] model_mul(input logic [15:0] a, input logic [15:0] b);
        int          ea, eb, fa, fb;
        int          pr, e, q, rem, half;
        logic        a_zero, b_zero, a_inf, b_inf;
        logic        a_nan, b_nan, a_snan, b_snan;
        logic        inf_zero;
        logic        s;
        logic [15:0] w;
        logic        ovf, inx, inv;
        ea = int'(a[14:10]);
        eb = int'(b[14:10]);
        fa = int'(a[9:0]);
        fb = int'(b[9:0]);
        // exponent zero flushes subnormals
        a_zero   = (ea == 0);
        b_zero   = (eb == 0);
        a_inf    = (ea == 31) && (fa == 0);
        b_inf    = (eb == 31) && (fb == 0);
        a_nan    = (ea == 31) && (fa != 0);
        b_nan    = (eb == 31) && (fb != 0);
        a_snan   = a_nan && !a[9];
        b_snan   = b_nan && !b[9];
        inf_zero = (a_inf && b_zero) || (a_zero && b_inf);
        s   = a[15] ^ b[15];
        w   = '0;
        ovf = 1'b0;
        inx = 1'b0;
        inv = 1'b0;
        if (a_nan || b_nan || inf_zero)
        begin
            w   = `FP16_QNAN;
            inv = inf_zero || a_snan || b_snan;
        end
        else if (a_inf || b_inf)
        begin
            w = {s, 5'h1F, 10'h000};
        end
        else if (a_zero || b_zero)
        begin
            w = {s, 15'h0000};
        end
        else
        begin
            // exact 22-bit significand product
            pr = (1024 + fa) * (1024 + fb);
            e  = ea + eb - `FP16_EXP_BIAS;
            if (pr >= (1 << 21))
            begin
                q    = pr >> 11;
                rem  = pr % 2048;
                half = 1024;
                e    = e + 1;
            end
            else
            begin
                q    = pr >> 10;
                rem  = pr % 1024;
                half = 512;
            end
            // nearest even
            if ((rem > half) || ((rem == half) && (q % 2 == 1)))
            begin
                q = q + 1;
            end
            if (q == 2048)
            begin
                q = 1024;
                e = e + 1;
            end
            inx = (rem != 0);
            if (e >= 31)
            begin
                w   = {s, 5'h1F, 10'h000};
                ovf = 1'b1;
                inx = 1'b1;
            end
            else if (e < 1)
            begin
                w   = {s, 15'h0000};
                inx = 1'b1;
            end
            else
            begin
                w = {s, 5'(e), 10'(q)};
            end
        end
        return {ovf, inx, inv, w};
    endfunction

    function automatic logic [15:0] make_fp(input logic s, input int e, input int f);
        return {s, 5'(e), 10'(f)};
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic logic [15:0] rand_normal();
        return make_fp(1'($urandom), rand_range(1, 30), int'($urandom % 1024));
    endfunction

    task automatic compare_field(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %s: got 0x%04h expected 0x%04h in cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_output();
        logic [15:0] exp_word;
        logic [2:0]  exp_flags;
        int          exp_cyc;
        if (out_valid)
        begin
            if (q_word.size() == 0)
            begin
                err_count++;
                $display("out_valid high in cycle %0d with no operation outstanding", cyc);
            end
            else
            begin
                exp_word  = q_word.pop_front();
                exp_flags = q_flags.pop_front();
                exp_cyc   = q_cyc.pop_front();
                if (exp_cyc != cyc)
                begin
                    err_count++;
                    $display("result came in cycle %0d but was due in cycle %0d", cyc, exp_cyc);
                end
                compare_field("product", product, exp_word);
                compare_field("overflow_flag", {15'b0, overflow_flag}, {15'b0, exp_flags[2]});
                compare_field("inexact_flag", {15'b0, inexact_flag}, {15'b0, exp_flags[1]});
                compare_field("invalid_flag", {15'b0, invalid_flag}, {15'b0, exp_flags[0]});
            end
        end
        else
        begin
            if ((q_cyc.size() != 0) && (q_cyc[0] <= cyc))
            begin
                // drop the missed entry so later ops stay aligned
                err_count++;
                $display("out_valid stayed low in cycle %0d where a result was due", cyc);
                void'(q_word.pop_front());
                void'(q_flags.pop_front());
                void'(q_cyc.pop_front());
            end
            // outputs must hold while idle
            compare_field("product", product, prev_word);
            compare_field("overflow_flag", {15'b0, overflow_flag}, {15'b0, prev_flags[2]});
            compare_field("inexact_flag", {15'b0, inexact_flag}, {15'b0, prev_flags[1]});
            compare_field("invalid_flag", {15'b0, invalid_flag}, {15'b0, prev_flags[0]});
        end
        prev_word  = product;
        prev_flags = {overflow_flag, inexact_flag, invalid_flag};
    endtask

    // sample mid-cycle away from both drive and capture
    always @(negedge clk)
    begin
        if (nRST && mon_on)
        begin
            check_output();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input logic [15:0] a, input logic [15:0] b);
        logic [18:0] r;
        r        = model_mul(a, b);
        a_in     = a;
        b_in     = b;
        in_valid = 1'b1;
        q_word.push_back(r[15:0]);
        q_flags.push_back(r[18:16]);
        // visible two edges after this drive
        q_cyc.push_back(cyc + 2);
        op_count++;
        next_cycle();
    endtask

    task automatic idle();
        // junk operands must be ignored
        in_valid = 1'b0;
        a_in     = 16'($urandom);
        b_in     = 16'($urandom);
        next_cycle();
    endtask

    task automatic clear_queue();
        q_word.delete();
        q_flags.delete();
        q_cyc.delete();
    endtask

    task automatic begin_test();
        test_num++;
        err_mark = err_count;
        op_mark  = op_count;
    endtask

    task automatic end_test(input string name);
        in_valid = 1'b0;
        while (q_word.size() != 0)
        begin
            next_cycle();
        end
        next_cycle();
        $display("test %0d %s: %0d ops, %0d errors", test_num, name,
                 op_count - op_mark, err_count - err_mark);
    endtask

    task automatic check_zero_outputs();
        compare_field("out_valid", {15'b0, out_valid}, 16'h0000);
        compare_field("product", product, 16'h0000);
        compare_field("overflow_flag", {15'b0, overflow_flag}, 16'h0000);
        compare_field("inexact_flag", {15'b0, inexact_flag}, 16'h0000);
        compare_field("invalid_flag", {15'b0, invalid_flag}, 16'h0000);
    endtask

    // async reset with ops still in the pipe
    task automatic reset_mid_run();
        nRST     = 1'b0;
        in_valid = 1'b0;
        clear_queue();
        @(negedge clk);
        check_zero_outputs();
        repeat (4) @(posedge clk);
        #1;
        nRST       = 1'b1;
        prev_word  = '0;
        prev_flags = '0;
        next_cycle();
    endtask

    initial
    begin
        #(WATCHDOG_CYC * CLK_PERIOD_NS);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        nRST     = 1'b0;
        in_valid = 1'b0;
        a_in     = '0;
        b_in     = '0;
        void'($urandom(74));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nRST   = 1'b1;
        mon_on = 1'b1;
        next_cycle();

        begin_test();
        repeat (N_RAND) issue(rand_normal(), rand_normal());
        end_test("random normal pairs");

        // every special against every special and a normal
        begin_test();
        for (int i = 0; i < 9; i++)
        begin
            for (int j = 0; j < 9; j++)
            begin
                issue(specials[i], specials[j]);
            end
            issue(specials[i], rand_normal());
            issue(rand_normal(), specials[i]);
        end
        end_test("special operands");

        begin_test();
        repeat (N_LARGE)
        begin
            issue(make_fp(1'($urandom), rand_range(22, 30), int'($urandom % 1024)),
                  make_fp(1'($urandom), rand_range(22, 30), int'($urandom % 1024)));
        end
        // 1.414^2 rounds up to 2.0 and carries into exponent 31
        issue(make_fp(1'b0, 30, 'h1A8), make_fp(1'b1, 15, 'h1A8));
        issue(make_fp(1'b0, 29, 'h1A8), make_fp(1'b0, 15, 'h1A8));
        issue(make_fp(1'b0, 30, 'h3FF), make_fp(1'b0, 15, 0));
        issue(make_fp(1'b1, 30, 'h3FF), make_fp(1'b0, 30, 'h3FF));
        end_test("large exponents");

        begin_test();
        repeat (N_SMALL)
        begin
            issue(make_fp(1'($urandom), rand_range(1, 12), int'($urandom % 1024)),
                  make_fp(1'($urandom), rand_range(1, 12), int'($urandom % 1024)));
        end
        repeat (N_SUB)
        begin
            issue(make_fp(1'($urandom), 0, rand_range(1, 1023)), rand_normal());
        end
        // rounding carry lifts exponent 0 to min normal
        issue(make_fp(1'b0, 1, 'h1A8), make_fp(1'b0, 14, 'h1A8));
        issue(make_fp(1'b1, 1, 0), make_fp(1'b0, 14, 0));
        end_test("small exponents and subnormals");

        begin_test();
        repeat (N_GAP)
        begin
            if ($urandom % 3 != 0)
            begin
                issue(16'($urandom), 16'($urandom));
            end
            else
            begin
                idle();
            end
        end
        end_test("random in_valid gaps");

        begin_test();
        repeat (N_RST) issue(rand_normal(), rand_normal());
        reset_mid_run();
        repeat (N_RST) issue(rand_normal(), rand_normal());
        end_test("reset mid run");

        $display("summary: %0d tests, %0d ops, %0d checks, %0d errors",
                 test_num, op_count, check_count, err_count);
        if (err_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
//////////////////////////////////////////////////
// free-running testbench clock, period set by
// parameter, starts low at time zero
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    // half period per phase
    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- src/fp16_mul_top.sv
//////////////////////////////////////////////////
// fp16 multiplier top, one operation per clock,
// result and flags two cycles after in_valid
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fp16_defines.svh"

module fp16_mul_top
    import fp16_pkg::*;
(
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   in_valid,
    input  logic [`FP16_WIDTH-1:0] a_in,
    input  logic [`FP16_WIDTH-1:0] b_in,
    output logic [`FP16_WIDTH-1:0] product,
    output logic                   out_valid,
    output logic                   overflow_flag,
    output logic                   inexact_flag,
    output logic                   invalid_flag
);

    // unpacked operands
    logic                       sign_a;
    logic                       sign_b;
    logic [`FP16_EXP_WIDTH-1:0] exp_a;
    logic [`FP16_EXP_WIDTH-1:0] exp_b;
    logic [`FP16_MAN_WIDTH:0]   sig_a;
    logic [`FP16_MAN_WIDTH:0]   sig_b;
    fp_class_t                  class_a;
    fp_class_t                  class_b;

    // tree outputs
    logic [12:0]                tree_result;
    logic                       tree_overflow;
    logic                       tree_round_loss;
    logic                       value_ready;

    // exponent path outputs, aligned with value_ready
    logic                       res_sign;
    logic signed [6:0]          exp_sum;
    fp_class_t                  res_class;

    fp16_unpack u_unpack_a (
        .op       (a_in),
        .sign     (sign_a),
        .exp      (exp_a),
        .sig      (sig_a),
        .op_class (class_a)
    );

    fp16_unpack u_unpack_b (
        .op       (b_in),
        .sign     (sign_b),
        .exp      (exp_b),
        .sig      (sig_b),
        .op_class (class_b)
    );

    mul_wallacetree u_tree (
        .clk         (clk),
        .nRST        (nRST),
        .a           (sig_a),
        .b           (sig_b),
        .active      (in_valid),
        .result      (tree_result),
        .overflow    (tree_overflow),
        .round_loss  (tree_round_loss),
        .value_ready (value_ready)
    );

    fp16_exp_path u_exp_path (
        .clk       (clk),
        .nRST      (nRST),
        .in_valid  (in_valid),
        .sign_a    (sign_a),
        .sign_b    (sign_b),
        .exp_a     (exp_a),
        .exp_b     (exp_b),
        .class_a   (class_a),
        .class_b   (class_b),
        .res_sign  (res_sign),
        .exp_sum   (exp_sum),
        .res_class (res_class)
    );

    fp16_round_pack u_round_pack (
        .clk           (clk),
        .nRST          (nRST),
        .value_ready   (value_ready),
        .result        (tree_result),
        .overflow      (tree_overflow),
        .round_loss    (tree_round_loss),
        .res_sign      (res_sign),
        .exp_sum       (exp_sum),
        .res_class     (res_class),
        .product       (product),
        .out_valid     (out_valid),
        .overflow_flag (overflow_flag),
        .inexact_flag  (inexact_flag),
        .invalid_flag  (invalid_flag)
    );

endmodule

`default_nettype wire

//--- src/fp16_round_pack.sv
//////////////////////////////////////////////////
// normalizes the tree output, rounds to nearest
// even, applies range limits and specials, and
// registers the packed word with its flags
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fp16_defines.svh"

module fp16_round_pack
    import fp16_pkg::*;
(
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   value_ready,
    input  logic [12:0]            result,
    input  logic                   overflow,
    input  logic                   round_loss,
    input  logic                   res_sign,
    input  logic signed [6:0]      exp_sum,
    input  fp_class_t              res_class,
    output logic [`FP16_WIDTH-1:0] product,
    output logic                   out_valid,
    output logic                   overflow_flag,
    output logic                   inexact_flag,
    output logic                   invalid_flag
);

    localparam logic [`FP16_EXP_WIDTH-1:0] EXP_ONES = `FP16_EXP_MAX;
    localparam logic signed [7:0]          EXP_TOP  = `FP16_EXP_MAX;
    localparam logic [`FP16_WIDTH-1:0]     QNAN     = `FP16_QNAN;

    logic [`FP16_MAN_WIDTH-1:0] frac;
    logic                       guard;
    logic                       sticky;
    logic                       round_up;
    logic [`FP16_MAN_WIDTH:0]   frac_rnd;
    logic signed [7:0]          exp_norm;
    logic signed [7:0]          exp_rnd;
    logic [`FP16_WIDTH-1:0]     product_next;
    logic                       ovf_next;
    logic                       inexact_next;
    logic                       invalid_next;

    // product in [2,4) shifts right by one
    assign frac   = overflow ? result[12:3] : result[11:2];
    assign guard  = overflow ? result[2] : result[1];
    assign sticky = overflow ? (|result[1:0] | round_loss) : (result[0] | round_loss);

    assign exp_norm = {exp_sum[6], exp_sum} + {7'b0, overflow};

    // nearest even, ties go to even lsb
    assign round_up = guard & (sticky | frac[0]);
    assign frac_rnd = {1'b0, frac} + {{`FP16_MAN_WIDTH{1'b0}}, round_up};
    // fraction wrap bumps exponent, fraction already zero
    assign exp_rnd  = exp_norm + {7'b0, frac_rnd[`FP16_MAN_WIDTH]};

    always_comb
    begin
        product_next = '0;
        ovf_next     = 1'b0;
        inexact_next = 1'b0;
        invalid_next = 1'b0;
        case (res_class)
            fp_zero:
            begin
                product_next = {res_sign, {(`FP16_WIDTH-1){1'b0}}};
            end
            fp_inf:
            begin
                product_next = {res_sign, EXP_ONES, {`FP16_MAN_WIDTH{1'b0}}};
            end
            fp_nan:
            begin
                product_next = QNAN;
                // marker from exponent path
                invalid_next = exp_sum[6];
            end
            default:
            begin
                if (exp_rnd >= EXP_TOP)
                begin
                    // too large, saturate to infinity
                    product_next = {res_sign, EXP_ONES, {`FP16_MAN_WIDTH{1'b0}}};
                    ovf_next     = 1'b1;
                    inexact_next = 1'b1;
                end
                else if (exp_rnd < 8'sd1)
                begin
                    // would be subnormal, flush
                    product_next = {res_sign, {(`FP16_WIDTH-1){1'b0}}};
                    inexact_next = 1'b1;
                end
                else
                begin
                    product_next = {res_sign, exp_rnd[`FP16_EXP_WIDTH-1:0],
                                    frac_rnd[`FP16_MAN_WIDTH-1:0]};
                    inexact_next = guard | sticky;
                end
            end
        endcase
    end

    // output word and flags hold between results
    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            product       <= '0;
            out_valid     <= 1'b0;
            overflow_flag <= 1'b0;
            inexact_flag  <= 1'b0;
            invalid_flag  <= 1'b0;
        end
        else
        begin
            out_valid <= value_ready;
            if (value_ready)
            begin
                product       <= product_next;
                overflow_flag <= ovf_next;
                inexact_flag  <= inexact_next;
                invalid_flag  <= invalid_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/fp16_exp_path.sv
//////////////////////////////////////////////////
// result sign, unbiased exponent sum and special
// class, registered in step with the tree stage
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fp16_defines.svh"

module fp16_exp_path
    import fp16_pkg::*;
(
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       in_valid,
    input  logic                       sign_a,
    input  logic                       sign_b,
    input  logic [`FP16_EXP_WIDTH-1:0] exp_a,
    input  logic [`FP16_EXP_WIDTH-1:0] exp_b,
    input  fp_class_t                  class_a,
    input  fp_class_t                  class_b,
    output logic                       res_sign,
    output logic signed [6:0]          exp_sum,
    output fp_class_t                  res_class
);

    localparam logic [6:0]        BIAS         = `FP16_EXP_BIAS;
    // bit 6 flags an invalid operation on the NaN path
    localparam logic signed [6:0] INVALID_MARK = 7'b100_0000;

    logic              any_nan;
    logic              any_inf;
    logic              any_zero;
    logic              inf_times_zero;
    logic              snan_in;
    logic signed [6:0] sum_next;
    fp_class_t         class_next;

    assign any_nan  = (class_a == fp_nan) || (class_b == fp_nan);
    assign any_inf  = (class_a == fp_inf) || (class_b == fp_inf);
    assign any_zero = (class_a == fp_zero) || (class_b == fp_zero);

    assign inf_times_zero = ((class_a == fp_inf) && (class_b == fp_zero)) ||
                            ((class_a == fp_zero) && (class_b == fp_inf));

    // unpack clears the exponent lsb for a signaling NaN
    assign snan_in = ((class_a == fp_nan) && !exp_a[0]) ||
                     ((class_b == fp_nan) && !exp_b[0]);

    always_comb
    begin
        sum_next = {2'b00, exp_a} + {2'b00, exp_b} - BIAS;
        // precedence: nan, inf, zero, normal
        if (any_nan || inf_times_zero)
        begin
            class_next = fp_nan;
            sum_next   = (inf_times_zero || snan_in) ? INVALID_MARK : '0;
        end
        else if (any_inf)
        begin
            class_next = fp_inf;
        end
        else if (any_zero)
        begin
            class_next = fp_zero;
        end
        else
        begin
            class_next = fp_normal;
        end
    end

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            res_sign  <= 1'b0;
            exp_sum   <= '0;
            res_class <= fp_zero;
        end
        else if (in_valid)
        begin
            res_sign  <= sign_a ^ sign_b;
            exp_sum   <= sum_next;
            res_class <= class_next;
        end
    end

endmodule

`default_nettype wire

//--- src/mul_wallacetree.sv
//////////////////////////////////////////////////
// 11x11 carry-save wallace tree for significands,
// four 3:2 stages, one register, a fifth stage and
// a final add; product split for the rounding step
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_wallacetree (
    input  logic        clk,
    input  logic        nRST,
    input  logic [10:0] a,
    input  logic [10:0] b,
    input  logic        active,
    output logic [12:0] result,
    output logic        overflow,
    output logic        round_loss,
    output logic        value_ready
);

    // full product width
    localparam int PW = 22;

    // partial product rows, shifted to weight
    logic [PW-1:0] pp   [11];
    // rows left after each stage
    logic [PW-1:0] s1   [8];
    logic [PW-1:0] s2   [6];
    logic [PW-1:0] s3   [4];
    logic [PW-1:0] s4   [3];
    // pipeline register between stage 4 and 5
    logic [PW-1:0] s4_q [3];
    logic [PW-1:0] s5   [2];
    logic [PW-1:0] prod;

    genvar i, g, k;

    generate
        for (i = 0; i < 11; i++)
        begin : g_pp
            assign pp[i] = {11'b0, a & {11{b[i]}}} << i;
        end
    endgenerate

    // stage 1: 11 rows -> 8
    // each cell is a full adder, carry lands one bit up
    generate
        for (g = 0; g < 3; g++)
        begin : g_s1
            for (k = 0; k < PW - 1; k++)
            begin : g_fa
                assign {s1[2*g+1][k+1], s1[2*g][k]} =
                    pp[3*g][k] + pp[3*g+1][k] + pp[3*g+2][k];
            end
            // carry out of the top bit cannot occur
            assign s1[2*g][PW-1] = pp[3*g][PW-1] ^ pp[3*g+1][PW-1] ^ pp[3*g+2][PW-1];
            assign s1[2*g+1][0]  = 1'b0;
        end
    endgenerate

    // two rows pass through
    assign s1[6] = pp[9];
    assign s1[7] = pp[10];

    // stage 2: 8 rows -> 6
    generate
        for (g = 0; g < 2; g++)
        begin : g_s2
            for (k = 0; k < PW - 1; k++)
            begin : g_fa
                assign {s2[2*g+1][k+1], s2[2*g][k]} =
                    s1[3*g][k] + s1[3*g+1][k] + s1[3*g+2][k];
            end
            assign s2[2*g][PW-1] = s1[3*g][PW-1] ^ s1[3*g+1][PW-1] ^ s1[3*g+2][PW-1];
            assign s2[2*g+1][0]  = 1'b0;
        end
    endgenerate

    assign s2[4] = s1[6];
    assign s2[5] = s1[7];

    // stage 3: 6 rows -> 4, nothing left over
    generate
        for (g = 0; g < 2; g++)
        begin : g_s3
            for (k = 0; k < PW - 1; k++)
            begin : g_fa
                assign {s3[2*g+1][k+1], s3[2*g][k]} =
                    s2[3*g][k] + s2[3*g+1][k] + s2[3*g+2][k];
            end
            assign s3[2*g][PW-1] = s2[3*g][PW-1] ^ s2[3*g+1][PW-1] ^ s2[3*g+2][PW-1];
            assign s3[2*g+1][0]  = 1'b0;
        end
    endgenerate

    // stage 4: 4 rows -> 3
    generate
        for (k = 0; k < PW - 1; k++)
        begin : g_s4
            assign {s4[1][k+1], s4[0][k]} = s3[0][k] + s3[1][k] + s3[2][k];
        end
    endgenerate

    assign s4[0][PW-1] = s3[0][PW-1] ^ s3[1][PW-1] ^ s3[2][PW-1];
    assign s4[1][0]    = 1'b0;
    assign s4[2]       = s3[3];

    // strobe follows active by one cycle
    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            value_ready <= 1'b0;
        end
        else
        begin
            value_ready <= active;
        end
    end

    // carry-save rows, held while idle
    always_ff @(posedge clk)
    begin
        if (active)
        begin
            s4_q <= s4;
        end
    end

    // stage 5: last 3 rows -> 2
    generate
        for (k = 0; k < PW - 1; k++)
        begin : g_s5
            assign {s5[1][k+1], s5[0][k]} = s4_q[0][k] + s4_q[1][k] + s4_q[2][k];
        end
    endgenerate

    assign s5[0][PW-1] = s4_q[0][PW-1] ^ s4_q[1][PW-1] ^ s4_q[2][PW-1];
    assign s5[1][0]    = 1'b0;

    // carry-propagate add
    assign prod = s5[0] + s5[1];

    // bit 21 set means the product is in [2,4)
    assign overflow   = prod[21];
    // 10 fraction bits plus guard and one spare
    assign result     = prod[20:8];
    assign round_loss = |prod[7:0];

endmodule

`default_nettype wire

//--- src/fp16_unpack.sv
//////////////////////////////////////////////////
// splits one fp16 operand into fields and sorts it
// into zero, normal, infinity or NaN
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fp16_defines.svh"

module fp16_unpack
    import fp16_pkg::*;
(
    input  logic [`FP16_WIDTH-1:0]     op,
    output logic                       sign,
    output logic [`FP16_EXP_WIDTH-1:0] exp,
    output logic [`FP16_MAN_WIDTH:0]   sig,
    output fp_class_t                  op_class
);

    localparam logic [`FP16_EXP_WIDTH-1:0] EXP_ONES = `FP16_EXP_MAX;

    logic [`FP16_EXP_WIDTH-1:0] exp_field;
    logic [`FP16_MAN_WIDTH-1:0] frac_field;
    logic                       quiet_bit;

    assign sign       = op[`FP16_WIDTH-1];
    assign exp_field  = op[`FP16_WIDTH-2 -: `FP16_EXP_WIDTH];
    assign frac_field = op[`FP16_MAN_WIDTH-1:0];
    assign quiet_bit  = frac_field[`FP16_MAN_WIDTH-1];

    always_comb
    begin
        if (exp_field == '0)
        begin
            // zero or subnormal, both flushed
            op_class = fp_zero;
            exp      = '0;
            sig      = '0;
        end
        else if (exp_field == EXP_ONES)
        begin
            op_class = (frac_field == '0) ? fp_inf : fp_nan;
            // signaling NaN marked by clearing the exponent lsb
            if ((frac_field != '0) && !quiet_bit)
            begin
                exp = EXP_ONES - 1'b1;
            end
            else
            begin
                exp = EXP_ONES;
            end
            sig = '0;
        end
        else
        begin
            // hidden bit only here
            op_class = fp_normal;
            exp      = exp_field;
            sig      = {1'b1, frac_field};
        end
    end

endmodule

`default_nettype wire

//--- src/fp16_pkg.sv
//////////////////////////////////////////////////
// shared types for the fp16 multiplier, imported
// by the blocks that pass operand classes around
//////////////////////////////////////////////////

`default_nettype none

package fp16_pkg;

    // operand and result class
    // zero also covers flushed subnormals
    typedef enum logic [1:0] {
        fp_zero   = 2'b00,
        fp_normal = 2'b01,
        fp_inf    = 2'b10,
        fp_nan    = 2'b11
    } fp_class_t;

endpackage

`default_nettype wire

//--- include/fp16_defines.svh
//////////////////////////////////////////////////
// half precision format constants, include where
// field widths, the bias or the canonical NaN are
// needed
//////////////////////////////////////////////////

`ifndef FP16_DEFINES_SVH
`define FP16_DEFINES_SVH

// word and field widths
`define FP16_WIDTH      16
`define FP16_EXP_WIDTH  5
`define FP16_MAN_WIDTH  10

// exponent bias
`define FP16_EXP_BIAS   15

// all-ones exponent, infinity and NaN
`define FP16_EXP_MAX    31

// canonical quiet NaN
// sign 0, exponent all ones, fraction msb set
`define FP16_QNAN       16'h7E00

`endif
